/* source/issue_pkg.sv */
`default_nettype none

package issue_pkg;

  ////////////////////////////////////////////////////////////
  // instruction word layout

  localparam int INST_WIDTH = 32;
  localparam int OPCODE_MSB = 31;
  localparam int OPCODE_LSB = 26;
  localparam int RS_MSB = 25;
  localparam int RS_LSB = 21;
  localparam int RT_MSB = 20;
  localparam int RT_LSB = 16;
  localparam int RD_MSB = 15;
  localparam int RD_LSB = 11;

  localparam int NUM_REGS = 32;
  localparam int PROG_DEPTH = 256;
  localparam int ID_WIDTH = 6;     // ids wrap modulo 64.

  typedef logic [INST_WIDTH-1:0] inst_t;
  typedef logic [OPCODE_MSB-OPCODE_LSB:0] opcode_t;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
  typedef logic [2:0] reg_use_t;
  typedef logic [$clog2(PROG_DEPTH)-1:0] addr_t;
  typedef logic [ID_WIDTH-1:0] id_t;
  typedef logic [1:0] slot_mask_t;   // bit n set, slot n may issue.

  typedef enum logic [1:0] {
    pipe_none,
    pipe_branch,
    pipe_memory
  } pipe_t;

  // bit positions in reg_use_t.
  localparam int USE_RS0 = 0;
  localparam int USE_RS1 = 1;
  localparam int USE_RD = 2;

  ////////////////////////////////////////////////////////////
  // opcodes, top two bits give the class

  localparam logic [1:0] CLASS_REG = 2'b00;
  localparam logic [1:0] CLASS_IMM = 2'b01;
  localparam logic [1:0] CLASS_MEM = 2'b10;
  localparam logic [1:0] CLASS_JUMP = 2'b11;

  localparam opcode_t OP_NOP = 6'b000000;
  localparam opcode_t OP_CMP = 6'b001110;
  localparam opcode_t OP_TEST = 6'b001111;
  localparam opcode_t OP_CMPI = 6'b011110;
  localparam opcode_t OP_TESTI = 6'b011111;
  localparam opcode_t OP_LW = 6'b100000;
  localparam opcode_t OP_SW = 6'b100001;
  localparam opcode_t OP_LA = 6'b100010;
  localparam opcode_t OP_SA = 6'b100011;
  localparam opcode_t OP_JR = 6'b111111;

endpackage

`default_nettype wire

/* source/fetch_pair.sv */
`default_nettype none

module fetch_pair import issue_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  flush,
  input  logic  run,
  input  logic  hold_busy,
  input  logic  prog_we,
  input  addr_t prog_addr,
  input  inst_t prog_data,
  output inst_t instruction0,
  output inst_t instruction1,
  output addr_t pc0,
  output addr_t pc1,
  output id_t   id0,
  output id_t   id1
);

  inst_t prog_mem [PROG_DEPTH];
  addr_t pc;
  id_t   id_count;

  ////////////////////////////////////////////////////////////
  // program memory

  always_ff @(posedge clk) begin
    if (prog_we && !run) begin
      prog_mem[prog_addr] <= prog_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // pc and id counter

  // the presented pair is consumed whenever nothing is held.
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
      id_count <= '0;
    end else if (flush) begin
      pc <= '0;                          // ids keep counting.
    end else if (run && !hold_busy) begin
      pc <= pc + addr_t'(2);
      id_count <= id_count + id_t'(2);
    end
  end

  assign pc0 = pc;
  assign pc1 = pc + addr_t'(1);          // wraps at the top.
  assign id0 = id_count;
  assign id1 = id_count + id_t'(1);

  assign instruction0 = run ? prog_mem[pc0] : '0;
  assign instruction1 = run ? prog_mem[pc1] : '0;

endmodule

`default_nettype wire

/* source/reg_depends.sv */
`default_nettype none

module reg_depends import issue_pkg::*; (
  input  inst_t    instruction,
  output reg_idx_t src0,
  output reg_idx_t src1,
  output reg_idx_t dest,
  output reg_use_t use_mask
);

  opcode_t  opcode;
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t rd;

  assign opcode = instruction[OPCODE_MSB:OPCODE_LSB];
  assign rs = instruction[RS_MSB:RS_LSB];
  assign rt = instruction[RT_MSB:RT_LSB];
  assign rd = instruction[RD_MSB:RD_LSB];

  always_comb begin
    src0 = '0;
    src1 = '0;
    dest = '0;
    use_mask = '0;
    case (opcode) inside
      OP_NOP, OP_LA, OP_SA: ;            // no register use.
      OP_JR: begin
        src0 = rs;
        use_mask[USE_RS0] = 1'b1;
      end
      OP_LW: begin
        src0 = rs;
        dest = rt;
        use_mask[USE_RS0] = 1'b1;
        use_mask[USE_RD] = 1'b1;
      end
      OP_SW: begin
        src0 = rs;
        src1 = rt;
        use_mask[USE_RS0] = 1'b1;
        use_mask[USE_RS1] = 1'b1;
      end
      6'b00????: begin                   // add, sub, cmp and friends.
        src0 = rs;
        src1 = rt;
        dest = rd;
        use_mask = reg_use_t'((1 << USE_RS0) | (1 << USE_RS1) | (1 << USE_RD));
      end
      6'b01????: begin                   // immediate forms write rt.
        src0 = rs;
        dest = rt;
        use_mask[USE_RS0] = 1'b1;
        use_mask[USE_RD] = 1'b1;
      end
      default: ;                         // other jumps.
    endcase
  end

endmodule

`default_nettype wire

/* source/load_hazard.sv */
`default_nettype none

module load_hazard import issue_pkg::*; (
  input  inst_t      instruction0,
  input  inst_t      instruction1,
  input  logic       prev_load,
  input  reg_idx_t   prev_rt,
  output slot_mask_t mask
);

  logic hit0;
  logic hit1;

  // field match only, the opcode is not decoded here.
  assign hit0 = (instruction0[RS_MSB:RS_LSB] == prev_rt) ||
                (instruction0[RT_MSB:RT_LSB] == prev_rt);
  assign hit1 = (instruction1[RS_MSB:RS_LSB] == prev_rt) ||
                (instruction1[RT_MSB:RT_LSB] == prev_rt);

  // the whole pair waits one cycle for the load.
  assign mask = (prev_load && (hit0 || hit1)) ? 2'b00 : 2'b11;

endmodule

`default_nettype wire

/* source/split_hazard.sv */
`default_nettype none

module split_hazard import issue_pkg::*; (
  input  inst_t      instruction0,
  input  inst_t      instruction1,
  input  slot_mask_t mask_in,
  output slot_mask_t mask_out
);

  inst_t    masked [2];
  reg_idx_t src0 [2];
  reg_idx_t src1 [2];
  reg_idx_t dest [2];
  reg_use_t use_mask [2];
  logic     raw;

  // a disabled slot decodes as a nop.
  assign masked[0] = mask_in[0] ? instruction0 : '0;
  assign masked[1] = mask_in[1] ? instruction1 : '0;

  for (genvar i = 0; i < 2; i++) begin : g_depends
    reg_depends i_reg_depends (
      .instruction (masked[i]),
      .src0        (src0[i]),
      .src1        (src1[i]),
      .dest        (dest[i]),
      .use_mask    (use_mask[i])
    );
  end

  // slot 1 reads what slot 0 writes.
  assign raw = use_mask[0][USE_RD] &&
               ((use_mask[1][USE_RS0] && (src0[1] == dest[0])) ||
                (use_mask[1][USE_RS1] && (src1[1] == dest[0])));

  assign mask_out = raw ? (mask_in & 2'b01) : mask_in;

endmodule

`default_nettype wire

/* source/pipe_steer.sv */
`default_nettype none

module pipe_steer import issue_pkg::*; (
  input  inst_t      instruction0,
  input  inst_t      instruction1,
  input  slot_mask_t mask_in,
  output slot_mask_t mask_out,
  output logic       swap
);

  pipe_t pipe0;
  pipe_t pipe1;
  logic  conflict;

  function automatic pipe_t classify(input inst_t instruction);
    opcode_t op;
    op = instruction[OPCODE_MSB:OPCODE_LSB];
    if (op[5:4] == CLASS_MEM) begin
      return pipe_memory;
    end
    if (op[5:4] == CLASS_JUMP) begin
      return pipe_branch;
    end
    // compares and tests set flags for the branch pipe.
    if ((op == OP_CMP) || (op == OP_TEST) || (op == OP_CMPI) || (op == OP_TESTI)) begin
      return pipe_branch;
    end
    return pipe_none;
  endfunction

  assign pipe0 = mask_in[0] ? classify(instruction0) : pipe_none;
  assign pipe1 = mask_in[1] ? classify(instruction1) : pipe_none;

  ////////////////////////////////////////////////////////////
  // conflict and swap

  assign conflict = (pipe0 == pipe1) && (pipe0 != pipe_none);

  // the later instruction waits.
  assign mask_out = conflict ? (mask_in & 2'b01) : mask_in;

  // memory leaves on slot 1, branch class on slot 0.
  assign swap = (pipe0 == pipe_memory) ||
                ((pipe1 == pipe_branch) && (pipe0 != pipe_branch));

endmodule

`default_nettype wire

/* source/issue_stage.sv */
`default_nettype none

module issue_stage import issue_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     flush,
  input  inst_t    instruction0,
  input  inst_t    instruction1,
  input  addr_t    pc0,
  input  addr_t    pc1,
  input  id_t      id0,
  input  id_t      id1,
  input  logic     prev_load,
  input  reg_idx_t prev_rt,
  output logic     hold_busy,
  output logic     issue_stall,
  output inst_t    issue0,
  output inst_t    issue1,
  output addr_t    issue0_pc,
  output addr_t    issue1_pc,
  output id_t      issue0_id,
  output id_t      issue1_id
);

  inst_t      hold_inst [2];
  addr_t      hold_pc [2];
  id_t        hold_id [2];
  inst_t      cur_inst [2];
  addr_t      cur_pc [2];
  id_t        cur_id [2];
  inst_t      out_inst [2];
  addr_t      out_pc [2];
  id_t        out_id [2];
  slot_mask_t load_mask;
  slot_mask_t split_mask;
  slot_mask_t steer_mask;
  logic       swap;
  logic [1:0] go;
  logic [1:0] keep;

  assign hold_busy = (hold_inst[0] != '0) || (hold_inst[1] != '0);

  // replay the held pair ahead of fetch.
  assign cur_inst[0] = hold_busy ? hold_inst[0] : instruction0;
  assign cur_inst[1] = hold_busy ? hold_inst[1] : instruction1;
  assign cur_pc[0] = hold_busy ? hold_pc[0] : pc0;
  assign cur_pc[1] = hold_busy ? hold_pc[1] : pc1;
  assign cur_id[0] = hold_busy ? hold_id[0] : id0;
  assign cur_id[1] = hold_busy ? hold_id[1] : id1;

  load_hazard i_load_hazard (
    .instruction0 (cur_inst[0]),
    .instruction1 (cur_inst[1]),
    .prev_load    (prev_load),
    .prev_rt      (prev_rt),
    .mask         (load_mask)
  );

  split_hazard i_split_hazard (
    .instruction0 (cur_inst[0]),
    .instruction1 (cur_inst[1]),
    .mask_in      (load_mask),
    .mask_out     (split_mask)
  );

  pipe_steer i_pipe_steer (
    .instruction0 (cur_inst[0]),
    .instruction1 (cur_inst[1]),
    .mask_in      (split_mask),
    .mask_out     (steer_mask),
    .swap         (swap)
  );

  assign issue_stall = !steer_mask[0] || !steer_mask[1];

  ////////////////////////////////////////////////////////////
  // issue and hold

  // empty slots leave as all zeros, pc and id included.
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      go[i] = steer_mask[i] && (cur_inst[i] != '0) && !flush;
      keep[i] = !steer_mask[i] && (cur_inst[i] != '0);
      out_inst[i] = go[i] ? cur_inst[i] : '0;
      out_pc[i] = go[i] ? cur_pc[i] : '0;
      out_id[i] = go[i] ? cur_id[i] : '0;
    end
  end

  assign issue0 = swap ? out_inst[1] : out_inst[0];
  assign issue1 = swap ? out_inst[0] : out_inst[1];
  assign issue0_pc = swap ? out_pc[1] : out_pc[0];
  assign issue1_pc = swap ? out_pc[0] : out_pc[1];
  assign issue0_id = swap ? out_id[1] : out_id[0];
  assign issue1_id = swap ? out_id[0] : out_id[1];

  // held slots keep their fetch position, not the steered one.
  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      if (reset || flush) begin
        hold_inst[i] <= '0;
        hold_pc[i] <= '0;
        hold_id[i] <= '0;
      end else begin
        hold_inst[i] <= keep[i] ? cur_inst[i] : '0;
        hold_pc[i] <= keep[i] ? cur_pc[i] : '0;
        hold_id[i] <= keep[i] ? cur_id[i] : '0;
      end
    end
  end

endmodule

`default_nettype wire

/* source/issue_latch.sv */
`default_nettype none

module issue_latch import issue_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     flush,
  input  inst_t    issue0,
  input  inst_t    issue1,
  input  addr_t    issue0_pc,
  input  addr_t    issue1_pc,
  input  id_t      issue0_id,
  input  id_t      issue1_id,
  output inst_t    ex0_instruction,
  output inst_t    ex1_instruction,
  output addr_t    ex0_pc,
  output addr_t    ex1_pc,
  output id_t      ex0_id,
  output id_t      ex1_id,
  output logic     prev_load,
  output reg_idx_t prev_rt
);

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      ex0_instruction <= '0;
      ex1_instruction <= '0;
      ex0_pc <= '0;
      ex1_pc <= '0;
      ex0_id <= '0;
      ex1_id <= '0;
    end else begin
      ex0_instruction <= issue0;
      ex1_instruction <= issue1;
      ex0_pc <= issue0_pc;
      ex1_pc <= issue1_pc;
      ex0_id <= issue0_id;
      ex1_id <= issue1_id;
    end
  end

  // loads only ever sit in slot 1.
  assign prev_load = (ex1_instruction[OPCODE_MSB:OPCODE_LSB] == OP_LW);
  assign prev_rt = ex1_instruction[RT_MSB:RT_LSB];

endmodule

`default_nettype wire

/* source/dual_issue_top.sv */
`default_nettype none

module dual_issue_top import issue_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  flush,
  input  logic  run,
  input  logic  prog_we,
  input  addr_t prog_addr,
  input  inst_t prog_data,
  output inst_t ex0_instruction,
  output inst_t ex1_instruction,
  output addr_t ex0_pc,
  output addr_t ex1_pc,
  output id_t   ex0_id,
  output id_t   ex1_id,
  output logic  issue_stall
);

  ////////////////////////////////////////////////////////////
  // fetch to issue

  inst_t    instruction0;
  inst_t    instruction1;
  addr_t    pc0;
  addr_t    pc1;
  id_t      id0;
  id_t      id1;
  logic     hold_busy;

  ////////////////////////////////////////////////////////////
  // issue to latch

  inst_t    issue0;
  inst_t    issue1;
  addr_t    issue0_pc;
  addr_t    issue1_pc;
  id_t      issue0_id;
  id_t      issue1_id;
  logic     prev_load;
  reg_idx_t prev_rt;

  fetch_pair i_fetch_pair (
    .clk          (clk),
    .reset        (reset),
    .flush        (flush),
    .run          (run),
    .hold_busy    (hold_busy),
    .prog_we      (prog_we),
    .prog_addr    (prog_addr),
    .prog_data    (prog_data),
    .instruction0 (instruction0),
    .instruction1 (instruction1),
    .pc0          (pc0),
    .pc1          (pc1),
    .id0          (id0),
    .id1          (id1)
  );

  issue_stage i_issue_stage (
    .clk          (clk),
    .reset        (reset),
    .flush        (flush),
    .instruction0 (instruction0),
    .instruction1 (instruction1),
    .pc0          (pc0),
    .pc1          (pc1),
    .id0          (id0),
    .id1          (id1),
    .prev_load    (prev_load),
    .prev_rt      (prev_rt),
    .hold_busy    (hold_busy),
    .issue_stall  (issue_stall),
    .issue0       (issue0),
    .issue1       (issue1),
    .issue0_pc    (issue0_pc),
    .issue1_pc    (issue1_pc),
    .issue0_id    (issue0_id),
    .issue1_id    (issue1_id)
  );

  issue_latch i_issue_latch (
    .clk             (clk),
    .reset           (reset),
    .flush           (flush),
    .issue0          (issue0),
    .issue1          (issue1),
    .issue0_pc       (issue0_pc),
    .issue1_pc       (issue1_pc),
    .issue0_id       (issue0_id),
    .issue1_id       (issue1_id),
    .ex0_instruction (ex0_instruction),
    .ex1_instruction (ex1_instruction),
    .ex0_pc          (ex0_pc),
    .ex1_pc          (ex1_pc),
    .ex0_id          (ex0_id),
    .ex1_id          (ex1_id),
    .prev_load       (prev_load),
    .prev_rt         (prev_rt)
  );

endmodule

`default_nettype wire

/* tests/dual_issue_assert.sv */
`default_nettype none

module dual_issue_assert import issue_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  flush,
  input  inst_t ex0_instruction,
  input  inst_t ex1_instruction,
  input  addr_t ex0_pc,
  input  addr_t ex1_pc,
  input  id_t   ex0_id,
  input  id_t   ex1_id,
  input  logic  issue_stall
);

  int unsigned failures;
  logic        all_zero;

  initial failures = 0;

  function automatic logic is_branch_class(inst_t w);
    opcode_t op;
    op = w[OPCODE_MSB:OPCODE_LSB];
    return (op[5:4] == CLASS_JUMP) || (op inside {OP_CMP, OP_TEST, OP_CMPI, OP_TESTI});
  endfunction

  // a real instruction naming register r in rs or rt.
  function automatic logic touches(inst_t w, reg_idx_t r);
    return (w != '0) && ((w[RS_MSB:RS_LSB] == r) || (w[RT_MSB:RT_LSB] == r));
  endfunction

  assign all_zero = (ex0_instruction == '0) && (ex1_instruction == '0) &&
                    (ex0_pc == '0) && (ex1_pc == '0) && (ex0_id == '0) && (ex1_id == '0);

  ////////////////////////////////////////////////////////////
  // steering

  memory_on_slot1: assert property (@(posedge clk) disable iff (reset)
    ex0_instruction[OPCODE_MSB -: 2] != CLASS_MEM)
  else begin
    $error("memory-class opcode on ex0_instruction: %h", ex0_instruction);
    failures++;
  end

  branch_on_slot0: assert property (@(posedge clk) disable iff (reset)
    !is_branch_class(ex1_instruction))
  else begin
    $error("branch-class opcode on ex1_instruction: %h", ex1_instruction);
    failures++;
  end

  ////////////////////////////////////////////////////////////
  // load-use, flush and reset

  load_use_gap: assert property (@(posedge clk) disable iff (reset)
    (ex1_instruction[OPCODE_MSB:OPCODE_LSB] == OP_LW) |=>
      !touches(ex0_instruction, $past(ex1_instruction[RT_MSB:RT_LSB])) &&
      !touches(ex1_instruction, $past(ex1_instruction[RT_MSB:RT_LSB])))
  else begin
    $error("instruction uses the load target in the cycle after the load");
    failures++;
  end

  flush_clears: assert property (@(posedge clk) disable iff (reset) flush |=> all_zero)
  else begin
    $error("ex outputs not zero in the cycle after flush");
    failures++;
  end

  // covers the cycle after reset falls too.
  reset_clears: assert property (@(posedge clk) reset |=> all_zero && !issue_stall)
  else begin
    $error("ex outputs or issue_stall not clear around reset");
    failures++;
  end

endmodule

bind dual_issue_top dual_issue_assert i_dual_issue_assert (.*);

`default_nettype wire

/* tests/dual_issue_tb.sv */
`default_nettype none

module dual_issue_tb import issue_pkg::*; ();

  localparam int PROG_WORDS = 60;
  localparam int FLUSH_AFTER = 12;     // checked instructions before the flush.
  localparam opcode_t OP_ADD = 6'b000001;
  localparam opcode_t OP_SUB = 6'b000010;
  localparam opcode_t OP_ADDI = 6'b010001;

  logic  clk;
  logic  reset;
  logic  flush;
  logic  run;
  logic  prog_we;
  addr_t prog_addr;
  inst_t prog_data;
  inst_t ex0_instruction;
  inst_t ex1_instruction;
  addr_t ex0_pc;
  addr_t ex1_pc;
  id_t   ex0_id;
  id_t   ex1_id;
  logic  issue_stall;

  inst_t       program_words [PROG_DEPTH];
  logic [31:0] lfsr_state;
  int          mismatch_count;
  int          other_count;
  int          checked_count;
  int          flush_count;
  int          next_pc;          // lowest pc still expected.
  id_t         id_offset;
  bit          id_known;
  bit          flush_pending;

  dual_issue_top i_dual_issue_top (
    .clk             (clk),
    .reset           (reset),
    .flush           (flush),
    .run             (run),
    .prog_we         (prog_we),
    .prog_addr       (prog_addr),
    .prog_data       (prog_data),
    .ex0_instruction (ex0_instruction),
    .ex1_instruction (ex1_instruction),
    .ex0_pc          (ex0_pc),
    .ex1_pc          (ex1_pc),
    .ex0_id          (ex0_id),
    .ex1_id          (ex1_id),
    .issue_stall     (issue_stall)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers

  function automatic logic [31:0] lfsr_next(logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic build_program;
    logic [31:0] pick;
    opcode_t     op;
    reg_idx_t    regs [3];
    for (int a = 0; a < PROG_DEPTH; a++) begin
      program_words[a] = '0;           // nop padding past the program.
    end
    for (int a = 0; a < PROG_WORDS; a++) begin
      draw_bits(4, pick);
      case (pick[3:0])
        4'd0, 4'd15: op = OP_NOP;
        4'd1, 4'd14: op = OP_ADD;
        4'd2: op = OP_SUB;
        4'd3: op = OP_ADDI;
        4'd4: op = OP_CMP;
        4'd5: op = OP_TEST;
        4'd6: op = OP_CMPI;
        4'd7: op = OP_TESTI;
        4'd8, 4'd9: op = OP_LW;
        4'd10: op = OP_SW;
        4'd11: op = OP_LA;
        4'd12: op = OP_SA;
        default: op = OP_JR;
      endcase
      for (int k = 0; k < 3; k++) begin
        draw_bits(2, pick);
        regs[k] = (pick[1:0] == 2'd0) ? reg_idx_t'(1) : reg_idx_t'(pick[1:0]);
      end
      program_words[a] = (op == OP_NOP) ? '0 : {op, regs[0], regs[1], regs[2], 11'b0};
    end
  endtask

  task automatic load_program;
    for (int a = 0; a < PROG_DEPTH; a++) begin
      @(posedge clk);
      #2;
      prog_we = 1'b1;
      prog_addr = addr_t'(a);
      prog_data = program_words[a];
    end
    @(posedge clk);
    #2;
    prog_we = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // reference rules

  // register that w writes or -1 for none.
  function automatic int dest_of(inst_t w);
    opcode_t op;
    op = w[OPCODE_MSB:OPCODE_LSB];
    if (op == OP_NOP) begin
      return -1;
    end
    case (op[5:4])
      CLASS_REG: return int'(w[RD_MSB:RD_LSB]);
      CLASS_IMM: return int'(w[RT_MSB:RT_LSB]);
      CLASS_MEM: return (op == OP_LW) ? int'(w[RT_MSB:RT_LSB]) : -1;
      default: return -1;
    endcase
  endfunction

  function automatic logic reads_reg(inst_t w, int r);
    opcode_t op;
    logic    rs_hit;
    logic    rt_hit;
    op = w[OPCODE_MSB:OPCODE_LSB];
    rs_hit = (r >= 0) && (int'(w[RS_MSB:RS_LSB]) == r);
    rt_hit = (r >= 0) && (int'(w[RT_MSB:RT_LSB]) == r);
    if (op == OP_NOP) begin
      return 1'b0;
    end
    case (op[5:4])
      CLASS_REG: return rs_hit || rt_hit;
      CLASS_IMM: return rs_hit;
      CLASS_MEM: return ((op == OP_LW) && rs_hit) || ((op == OP_SW) && (rs_hit || rt_hit));
      default: return (op == OP_JR) && rs_hit;
    endcase
  endfunction

  function automatic int next_nonzero(int from);
    for (int a = from; a < PROG_WORDS; a++) begin
      if (program_words[a] != '0) begin
        return a;
      end
    end
    return PROG_WORDS;
  endfunction

  ////////////////////////////////////////////////////////////
  // scoreboard

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    mismatch_count++;
    $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, expected);
  endtask

  task automatic check_slot(input string name, input inst_t inst, input addr_t pc,
                            input id_t id);
    assert (next_pc < PROG_WORDS) else begin
      other_count++;
      $display("ERROR: %s issued %h at pc %h after the program was complete", name, inst, pc);
    end
    if (next_pc < PROG_WORDS) begin
      assert (int'(pc) == next_pc) else report_mismatch({name, "_pc"}, pc, next_pc);
      assert (inst == program_words[pc])
        else report_mismatch({name, "_instruction"}, inst, program_words[pc]);
      if (!id_known) begin
        id_offset = id - id_t'(pc);    // ids keep counting across a flush.
        id_known = 1'b1;
      end else begin
        assert (id == id_t'(pc) + id_offset)
          else report_mismatch({name, "_id"}, id, id_t'(pc) + id_offset);
      end
      next_pc = next_nonzero(int'(pc) + 1);
      checked_count++;
    end
  endtask

  task automatic check_cycle;
    inst_t inst [2];
    addr_t pc [2];
    id_t   id [2];
    int    lo;
    int    hi;
    inst[0] = ex0_instruction;
    inst[1] = ex1_instruction;
    pc[0] = ex0_pc;
    pc[1] = ex1_pc;
    id[0] = ex0_id;
    id[1] = ex1_id;
    if (flush_pending) begin
      for (int k = 0; k < 2; k++) begin
        assert (inst[k] == '0)
          else report_mismatch($sformatf("ex%0d_instruction", k), inst[k], '0);
        assert (pc[k] == '0) else report_mismatch($sformatf("ex%0d_pc", k), pc[k], '0);
        assert (id[k] == '0) else report_mismatch($sformatf("ex%0d_id", k), id[k], '0);
      end
      next_pc = next_nonzero(0);       // order restarts from pc 0.
      id_known = 1'b0;
      flush_count++;
    end else begin
      lo = ((inst[0] != '0) && (inst[1] != '0) && (pc[1] < pc[0])) ? 1 : 0;
      hi = 1 - lo;
      if (inst[lo] != '0) begin
        check_slot($sformatf("ex%0d", lo), inst[lo], pc[lo], id[lo]);
      end
      if (inst[hi] != '0) begin
        check_slot($sformatf("ex%0d", hi), inst[hi], pc[hi], id[hi]);
      end
      if ((inst[lo] != '0) && (inst[hi] != '0)) begin
        assert (!reads_reg(inst[hi], dest_of(inst[lo]))) else begin
          other_count++;
          $display("ERROR: pc %h reads a register written by pc %h in the same pair",
                   pc[hi], pc[lo]);
        end
      end
    end
    flush_pending = flush;
  endtask

  // outputs settle after the rising edge.
  always @(negedge clk) begin
    if (!reset) begin
      check_cycle();
    end
  end

  ////////////////////////////////////////////////////////////
  // waits and end of run

  task automatic wait_for_checked(input int count, input int limit, output bit ok);
    for (int cycles = 0; (cycles < limit) && (checked_count < count); cycles++) begin
      @(posedge clk);
    end
    ok = (checked_count >= count);
    if (!ok) begin
      other_count++;
      $display("ERROR: timed out with %0d of %0d instructions checked", checked_count, count);
    end
  endtask

  task automatic wait_for_program_end(input int limit, output bit ok);
    for (int cycles = 0; (cycles < limit) && !((flush_count == 1) && (next_pc >= PROG_WORDS));
         cycles++) begin
      @(posedge clk);
    end
    ok = (flush_count == 1) && (next_pc >= PROG_WORDS);
    if (!ok) begin
      other_count++;
      $display("ERROR: timed out before the program completed after the flush, next pc %0d",
               next_pc);
    end
  endtask

  task automatic finish_run;
    int assert_failures;
    assert_failures = int'(i_dual_issue_top.i_dual_issue_assert.failures);
    $display("errors: %0d mismatches, %0d other, %0d assertion failures, %0d checked",
             mismatch_count, other_count, assert_failures, checked_count);
    if ((mismatch_count + other_count + assert_failures) == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  initial begin
    bit ok;
    reset = 1'b1;
    flush = 1'b0;
    run = 1'b0;
    prog_we = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    lfsr_state = 32'h7d26_513e;
    mismatch_count = 0;
    other_count = 0;
    checked_count = 0;
    flush_count = 0;
    flush_pending = 1'b0;
    id_known = 1'b1;                   // id equals pc after reset.
    id_offset = '0;
    build_program();
    next_pc = next_nonzero(0);
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;
    load_program();
    run = 1'b1;
    wait_for_checked(FLUSH_AFTER, 400, ok);
    if (ok) begin
      #2;
      flush = 1'b1;
      @(posedge clk);
      #2;
      flush = 1'b0;
      wait_for_program_end(800, ok);
    end
    if (ok) begin
      #2;
      run = 1'b0;
      repeat (4) @(posedge clk);
    end
    finish_run();
  end

endmodule

`default_nettype wire

/* project.f */
source/issue_pkg.sv
source/fetch_pair.sv
source/reg_depends.sv
source/load_hazard.sv
source/split_hazard.sv
source/pipe_steer.sv
source/issue_stage.sv
source/issue_latch.sv
source/dual_issue_top.sv
tests/dual_issue_assert.sv
tests/dual_issue_tb.sv
